// ==== verilog/cache_pkg.sv ====
// cache geometry and shared types; the way count is fixed at 2 because LRU state is one bit per set
package cache_pkg;

    localparam int addr_w      = 32;
    localparam int line_bytes  = 16;
    localparam int num_sets    = 64;
    localparam int num_ways    = 2;   // fixed by the one-bit LRU
    localparam int tag_w       = 22;
    localparam int mem_credits = 2;   // memory command credits granted after reset

    typedef logic [addr_w-1:0]               addr_t;
    typedef logic [31:0]                     word_t;
    typedef logic [line_bytes*8-1:0]         line_t;
    typedef logic [tag_w-1:0]                tag_t;
    typedef logic [$clog2(num_sets)-1:0]     index_t;   // addr bits 9:4
    typedef logic [$clog2(line_bytes)-1:0]   offset_t;  // addr bits 3:0
    typedef logic [1:0]                      size_t;

    // access size codes
    localparam size_t size_word = 2'd0;
    localparam size_t size_byte = 2'd1;
    localparam size_t size_half = 2'd2;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_evict,    // dirty victim write-back
        st_refill,   // line read from memory
        st_respond
    } ctrl_state_t;

endpackage

// ==== verilog/cache_way.sv ====
`timescale 1ns/1ps
// one way of the cache; write data comes low-aligned and an access must not cross a word
module cache_way (
    input  logic             clk,
    input  logic             rst_n,
    input  cache_pkg::addr_t addr,
    input  logic             sel,
    input  logic             store,
    input  logic             fill,
    input  cache_pkg::size_t size,
    input  cache_pkg::word_t wdata,
    input  cache_pkg::line_t fill_data,
    output logic             hit,
    output logic             dirty,
    output cache_pkg::tag_t  tag_out,
    output cache_pkg::word_t rdata,
    output cache_pkg::line_t line_out
);
    import cache_pkg::*;

    tag_t    tag_mem   [num_sets];
    logic    valid_mem [num_sets];
    logic    dirty_mem [num_sets];
    line_t   data_mem  [num_sets];

    index_t  index;
    offset_t offset;
    tag_t    addr_tag;
    word_t   lane_bits;
    line_t   lane_mask;
    line_t   lane_data;

    assign offset   = addr[$bits(offset_t)-1:0];
    assign index    = addr[$bits(offset_t) +: $bits(index_t)];
    assign addr_tag = addr[addr_w-1 -: tag_w];

    assign hit      = valid_mem[index] && (tag_mem[index] == addr_tag);
    assign dirty    = dirty_mem[index];
    assign tag_out  = tag_mem[index];
    assign line_out = data_mem[index];
    assign rdata    = data_mem[index][offset[3:2]*$bits(word_t) +: $bits(word_t)]; // whole word

    always_comb begin
        case (size)
            size_byte: lane_bits = 32'h0000_00ff;
            size_half: lane_bits = 32'h0000_ffff;
            default:   lane_bits = 32'hffff_ffff;
        endcase
        lane_mask = line_t'(lane_bits) << {offset, 3'b000};  // bytes touched by the store
        lane_data = line_t'(wdata) << {offset, 3'b000};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_sets; i++) begin
                tag_mem[i]   <= '0;
                valid_mem[i] <= 1'b0;
                dirty_mem[i] <= 1'b0;
                data_mem[i]  <= '0;
            end
        end else if (sel && fill) begin
            data_mem[index]  <= fill_data;
            tag_mem[index]   <= addr_tag;
            valid_mem[index] <= 1'b1;
            dirty_mem[index] <= 1'b0;    // fresh copy of memory
        end else if (sel && store) begin
            data_mem[index]  <= (data_mem[index] & ~lane_mask) | (lane_data & lane_mask);
            dirty_mem[index] <= 1'b1;
        end
    end

endmodule

// ==== verilog/cache_replace.sv ====
`timescale 1ns/1ps
// LRU state for a two-way cache; victim is combinational on index, update lands one cycle later
module cache_replace (
    input  logic              clk,
    input  logic              rst_n,
    input  cache_pkg::index_t index,
    input  logic              touch,
    input  logic              touch_way,
    output logic              victim
);
    import cache_pkg::*;

    logic lru_mem [num_sets];   // way that was used least recently

    assign victim = lru_mem[index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_sets; i++) begin
                lru_mem[i] <= 1'b0;   // way 0 is filled first
            end
        end else if (touch) begin
            lru_mem[index] <= !touch_way;   // other way becomes the victim
        end
    end

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps
// cache controller; one request in flight, one miss at a time, refill data always accepted
module cache_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cpu_req_valid,
    input  logic                           cpu_req_write,
    input  cache_pkg::addr_t               cpu_req_addr,
    input  cache_pkg::size_t               cpu_req_size,
    input  cache_pkg::word_t               cpu_req_wdata,
    input  logic [cache_pkg::num_ways-1:0] way_hit,
    input  logic [cache_pkg::num_ways-1:0] way_dirty,
    input  cache_pkg::tag_t                way_tag0,
    input  cache_pkg::tag_t                way_tag1,
    input  cache_pkg::word_t               way_rdata0,
    input  cache_pkg::word_t               way_rdata1,
    input  cache_pkg::line_t               way_line0,
    input  cache_pkg::line_t               way_line1,
    input  logic                           victim,
    input  logic                           mem_credit,
    input  logic                           mem_rsp_valid,
    input  cache_pkg::line_t               mem_rsp_rdata,
    output logic                           cpu_credit,
    output logic                           cpu_rsp_valid,
    output cache_pkg::word_t               cpu_rsp_rdata,
    output logic                           cpu_rsp_hit,
    output cache_pkg::addr_t               req_addr,
    output cache_pkg::size_t               req_size,
    output cache_pkg::word_t               req_wdata,
    output logic [cache_pkg::num_ways-1:0] way_sel,
    output logic                           way_store,
    output logic                           way_fill,
    output logic                           touch,
    output logic                           touch_way,
    output logic                           mem_cmd_valid,
    output logic                           mem_cmd_write,
    output cache_pkg::addr_t               mem_cmd_addr,
    output cache_pkg::line_t               mem_cmd_wdata
);
    import cache_pkg::*;

    typedef logic [$clog2(mem_credits + 1)-1:0] credit_t;

    ctrl_state_t state_q;
    logic        req_write_q;
    logic        boot_q;      // first cycle out of reset
    logic        hit_q;
    logic        way_q;       // hit way or refill victim
    logic        rd_sent_q;   // refill read issued
    credit_t     credit_q;
    word_t       fill_word_q;
    tag_t        req_tag;
    index_t      req_index;
    offset_t     req_offset;
    logic        any_hit;
    word_t       rsp_word;
    word_t       rsp_shift;

    assign req_offset = req_addr[$bits(offset_t)-1:0];
    assign req_index  = req_addr[$bits(offset_t) +: $bits(index_t)];
    assign req_tag    = req_addr[addr_w-1 -: tag_w];
    assign any_hit    = |way_hit;

    assign way_sel   = (state_q == st_lookup) ? way_hit : {way_q, !way_q};
    assign way_store = req_write_q && (((state_q == st_lookup) && any_hit) ||
                                       ((state_q == st_respond) && !hit_q));
    assign way_fill  = (state_q == st_refill) && rd_sent_q && mem_rsp_valid;
    assign touch     = (state_q == st_respond);
    assign touch_way = way_q;

    always_comb begin
        mem_cmd_valid = 1'b0;
        mem_cmd_write = 1'b0;
        mem_cmd_addr  = {req_tag, req_index, offset_t'(0)};
        mem_cmd_wdata = way_q ? way_line1 : way_line0;
        if (state_q == st_evict) begin
            mem_cmd_valid = (credit_q != '0);
            mem_cmd_write = 1'b1;
            mem_cmd_addr  = {(way_q ? way_tag1 : way_tag0), req_index, offset_t'(0)}; // victim home
        end else if (state_q == st_refill) begin
            mem_cmd_valid = (credit_q != '0) && !rd_sent_q;
        end
    end

    // miss reads return the word captured from the refill line
    assign rsp_word      = hit_q ? (way_q ? way_rdata1 : way_rdata0) : fill_word_q;
    assign rsp_shift     = rsp_word >> {req_offset[1:0], 3'b000};
    assign cpu_rsp_valid = (state_q == st_respond);
    assign cpu_rsp_hit   = hit_q;

    always_comb begin
        case (req_size)
            size_byte: cpu_rsp_rdata = {24'd0, rsp_shift[7:0]};
            size_half: cpu_rsp_rdata = {16'd0, rsp_shift[15:0]};
            default:   cpu_rsp_rdata = rsp_shift;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            boot_q     <= 1'b1;
            cpu_credit <= 1'b0;
            hit_q      <= 1'b0;
            way_q      <= 1'b0;
            rd_sent_q  <= 1'b0;
            credit_q   <= '0;
        end else begin
            boot_q     <= 1'b0;
            cpu_credit <= boot_q || (state_q == st_respond);
            credit_q   <= credit_q + credit_t'(mem_credit) - credit_t'(mem_cmd_valid);
            case (state_q)
                st_idle: begin
                    if (cpu_req_valid) begin
                        state_q <= st_lookup;
                    end
                end
                st_lookup: begin
                    hit_q     <= any_hit;
                    way_q     <= any_hit ? way_hit[1] : victim;
                    rd_sent_q <= 1'b0;
                    if (any_hit) begin
                        state_q <= st_respond;
                    end else if (way_dirty[victim]) begin
                        state_q <= st_evict;
                    end else begin
                        state_q <= st_refill;
                    end
                end
                st_evict: begin
                    if (mem_cmd_valid) begin
                        state_q <= st_refill;   // write-back needs no reply
                    end
                end
                st_refill: begin
                    if (mem_cmd_valid) begin
                        rd_sent_q <= 1'b1;
                    end
                    if (way_fill) begin
                        state_q <= st_respond;
                    end
                end
                default: begin
                    state_q <= st_idle;   // st_respond
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && cpu_req_valid) begin
            req_addr    <= cpu_req_addr;
            req_size    <= cpu_req_size;
            req_wdata   <= cpu_req_wdata;
            req_write_q <= cpu_req_write;
        end
        if (way_fill) begin
            fill_word_q <= mem_rsp_rdata[req_offset[3:2]*$bits(word_t) +: $bits(word_t)];
        end
    end

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ps
// two-way write-back data cache; one credit toward the processor, credit-based memory commands
module cache_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cpu_req_valid,
    input  logic             cpu_req_write,
    input  cache_pkg::addr_t cpu_req_addr,
    input  cache_pkg::size_t cpu_req_size,
    input  cache_pkg::word_t cpu_req_wdata,
    output logic             cpu_credit,
    output logic             cpu_rsp_valid,
    output cache_pkg::word_t cpu_rsp_rdata,
    output logic             cpu_rsp_hit,
    input  logic             mem_credit,
    input  logic             mem_rsp_valid,
    input  cache_pkg::line_t mem_rsp_rdata,
    output logic             mem_cmd_valid,
    output logic             mem_cmd_write,
    output cache_pkg::addr_t mem_cmd_addr,
    output cache_pkg::line_t mem_cmd_wdata
);
    import cache_pkg::*;

    addr_t               req_addr;
    size_t               req_size;
    word_t               req_wdata;
    logic [num_ways-1:0] way_sel;
    logic                way_store;
    logic                way_fill;
    logic [num_ways-1:0] way_hit;
    logic [num_ways-1:0] way_dirty;
    tag_t                way_tag0;
    tag_t                way_tag1;
    word_t               way_rdata0;
    word_t               way_rdata1;
    line_t               way_line0;
    line_t               way_line1;
    logic                touch;
    logic                touch_way;
    logic                victim;

    cache_way way0_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (req_addr),
        .sel       (way_sel[0]),
        .store     (way_store),
        .fill      (way_fill),
        .size      (req_size),
        .wdata     (req_wdata),
        .fill_data (mem_rsp_rdata),
        .hit       (way_hit[0]),
        .dirty     (way_dirty[0]),
        .tag_out   (way_tag0),
        .rdata     (way_rdata0),
        .line_out  (way_line0)
    );

    cache_way way1_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (req_addr),
        .sel       (way_sel[1]),
        .store     (way_store),
        .fill      (way_fill),
        .size      (req_size),
        .wdata     (req_wdata),
        .fill_data (mem_rsp_rdata),
        .hit       (way_hit[1]),
        .dirty     (way_dirty[1]),
        .tag_out   (way_tag1),
        .rdata     (way_rdata1),
        .line_out  (way_line1)
    );

    cache_replace replace_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (req_addr[$bits(offset_t) +: $bits(index_t)]),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

    cache_ctrl ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_write (cpu_req_write),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_size  (cpu_req_size),
        .cpu_req_wdata (cpu_req_wdata),
        .way_hit       (way_hit),
        .way_dirty     (way_dirty),
        .way_tag0      (way_tag0),
        .way_tag1      (way_tag1),
        .way_rdata0    (way_rdata0),
        .way_rdata1    (way_rdata1),
        .way_line0     (way_line0),
        .way_line1     (way_line1),
        .victim        (victim),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata),
        .cpu_credit    (cpu_credit),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_rdata (cpu_rsp_rdata),
        .cpu_rsp_hit   (cpu_rsp_hit),
        .req_addr      (req_addr),
        .req_size      (req_size),
        .req_wdata     (req_wdata),
        .way_sel       (way_sel),
        .way_store     (way_store),
        .way_fill      (way_fill),
        .touch         (touch),
        .touch_way     (touch_way),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_write (mem_cmd_write),
        .mem_cmd_addr  (mem_cmd_addr),
        .mem_cmd_wdata (mem_cmd_wdata)
    );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps
// 4 ns clock; rst_n is released on a falling edge after 8 rising edges
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);   // away from the sampling point
        rst_n = 1'b1;
    end

endmodule

// ==== dv/cache_tb.sv ====
`timescale 1ns/1ps
// reads dv/cache_trace.txt relative to the run directory; one request in flight at a time
module cache_tb;
    import cache_pkg::*;

    logic  clk;
    logic  rst_n;
    logic  cpu_req_valid;
    logic  cpu_req_write;
    addr_t cpu_req_addr;
    size_t cpu_req_size;
    word_t cpu_req_wdata;
    logic  cpu_credit;
    logic  cpu_rsp_valid;
    word_t cpu_rsp_rdata;
    logic  cpu_rsp_hit;
    logic  mem_credit;
    logic  mem_rsp_valid;
    line_t mem_rsp_rdata;
    logic  mem_cmd_valid;
    logic  mem_cmd_write;
    addr_t mem_cmd_addr;
    line_t mem_cmd_wdata;

    // trace columns
    logic [31:0] t_op [$];
    addr_t       t_addr [$];
    size_t       t_size [$];
    word_t       t_wdata [$];
    word_t       t_rdata [$];
    logic        t_hit [$];

    word_t       mem_words [addr_t];     // written-back words by word address
    word_t       shadow_words [addr_t];  // what the processor has written
    logic        dirty_lines [addr_t];   // lines written and not yet written back
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          cycle_limit;
    int          cpu_credits;
    int          mem_owed;               // credits the memory still has to grant
    int          mem_given;              // credits held by the cache
    int          rsp_delay;
    addr_t       rsp_addr;
    addr_t       req_line;               // line of the request in flight
    logic        hold_credits;

    tb_clock clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cache_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_write (cpu_req_write),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_size  (cpu_req_size),
        .cpu_req_wdata (cpu_req_wdata),
        .cpu_credit    (cpu_credit),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_rdata (cpu_rsp_rdata),
        .cpu_rsp_hit   (cpu_rsp_hit),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_write (mem_cmd_write),
        .mem_cmd_addr  (mem_cmd_addr),
        .mem_cmd_wdata (mem_cmd_wdata)
    );

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic int take_bits(int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return val;
    endfunction

    function automatic word_t memory_word(addr_t a);
        if (mem_words.exists(a >> 2)) begin
            return mem_words[a >> 2];
        end
        return word_t'(a >> 2) ^ 32'h5a5a_0000;   // untouched memory pattern
    endfunction

    function automatic word_t shadow_word(addr_t a);
        if (shadow_words.exists(a >> 2)) begin
            return shadow_words[a >> 2];
        end
        return word_t'(a >> 2) ^ 32'h5a5a_0000;
    endfunction

    task automatic shadow_write(addr_t a, size_t sz, word_t d);
        word_t w;
        word_t mask;
        int    sh;
        w  = shadow_word(a);
        sh = int'(a[1:0]) * 8;
        case (sz)
            size_byte: mask = 32'h0000_00ff;
            size_half: mask = 32'h0000_ffff;
            default:   mask = 32'hffff_ffff;
        endcase
        w = (w & ~(mask << sh)) | ((d & mask) << sh);
        shadow_words[a >> 2] = w;
    endtask

    // sample outputs 1 ns after each edge, then run the memory model
    task automatic step();
        line_t expect_line;
        @(posedge clk);
        #1;
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
        if (cpu_credit) cpu_credits++;
        mem_credit    = 1'b0;
        mem_rsp_valid = 1'b0;
        if (rsp_delay > 0) begin
            rsp_delay--;
            if (rsp_delay == 0) begin
                mem_rsp_valid = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    mem_rsp_rdata[i*32 +: 32] = memory_word(rsp_addr + addr_t'(4 * i));
                end
            end
        end
        if (mem_cmd_valid) begin
            assert (mem_given > 0) else report_failure("memory command issued without a credit");
            assert (mem_cmd_addr[3:0] == 4'h0) else report_failure(
                $sformatf("Error: mem_cmd_addr %h is not line aligned", mem_cmd_addr));
            mem_given--;
            mem_owed++;
            if (mem_cmd_write) begin
                assert (dirty_lines.exists(mem_cmd_addr >> 4)) else report_failure($sformatf(
                    "Error: mem_cmd_addr %h is written back but holds no processor write",
                    mem_cmd_addr));
                dirty_lines.delete(mem_cmd_addr >> 4);
                for (int i = 0; i < 4; i++) begin
                    expect_line[i*32 +: 32] = shadow_word(mem_cmd_addr + addr_t'(4 * i));
                end
                assert (mem_cmd_wdata == expect_line) else report_failure($sformatf(
                    "Error: mem_cmd_wdata at mem_cmd_addr %h is %h, expected %h",
                    mem_cmd_addr, mem_cmd_wdata, expect_line));
                for (int i = 0; i < 4; i++) begin
                    mem_words[(mem_cmd_addr >> 2) + addr_t'(i)] = mem_cmd_wdata[i*32 +: 32];
                end
            end else begin
                assert (mem_cmd_addr == req_line) else report_failure($sformatf(
                    "Error: mem_cmd_addr %h for a refill read, expected %h",
                    mem_cmd_addr, req_line));
                assert (rsp_delay == 0) else report_failure(
                    "refill read issued while one is pending");
                rsp_addr  = mem_cmd_addr;
                rsp_delay = 2 + take_bits(2);   // 2 to 5 cycles
            end
        end
        if (rst_n && !hold_credits && mem_owed > 0) begin
            mem_credit = 1'b1;
            mem_owed--;
            mem_given++;
        end
    endtask

    task automatic run_request(int i);
        int lat;
        while (cpu_credits == 0) step();
        cpu_credits--;
        if (t_op[i] != 2) hold_credits = 1'b0;
        req_line      = {t_addr[i][31:4], 4'h0};
        cpu_req_valid = 1'b1;
        cpu_req_write = (t_op[i] == 1);
        cpu_req_addr  = t_addr[i];
        cpu_req_size  = t_size[i];
        cpu_req_wdata = t_wdata[i];
        if (t_op[i] == 1) begin
            shadow_write(t_addr[i], t_size[i], t_wdata[i]);
            dirty_lines[t_addr[i] >> 4] = 1'b1;
        end
        lat = 0;
        if (t_op[i] == 2) begin   // memory stalled for a while
            repeat (20) begin
                step();
                cpu_req_valid = 1'b0;
                lat++;
                assert (!mem_cmd_valid) else report_failure(
                    "memory command issued while memory credits were withheld");
                assert (!cpu_credit && !cpu_rsp_valid) else report_failure(
                    "processor got a credit or response while memory credits were withheld");
            end
            hold_credits = 1'b0;
        end
        do begin
            step();
            cpu_req_valid = 1'b0;
            lat++;
        end while (!cpu_rsp_valid);
        assert (cpu_rsp_hit == t_hit[i]) else report_failure($sformatf(
            "Error: cpu_rsp_hit for address %h is %h, expected %h",
            t_addr[i], cpu_rsp_hit, t_hit[i]));
        if (t_op[i] != 1) begin
            assert (cpu_rsp_rdata == t_rdata[i]) else report_failure($sformatf(
                "Error: cpu_rsp_rdata for address %h is %h, expected %h",
                t_addr[i], cpu_rsp_rdata, t_rdata[i]));
        end
        if (t_hit[i]) begin
            assert (lat == 2) else report_failure($sformatf(
                "hit response came %0d cycles after the request instead of 2", lat));
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       text;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_size;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        logic [31:0] f_hit;
        cpu_req_valid = 1'b0;
        cpu_req_write = 1'b0;
        cpu_req_addr  = '0;
        cpu_req_size  = size_word;
        cpu_req_wdata = '0;
        mem_credit    = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_rdata = '0;
        lfsr_state    = 32'hdb4c_ab31;
        hold_credits  = 1'b1;    // first trace entry runs against a stalled memory
        mem_owed      = mem_credits;
        mem_given     = 0;
        rsp_delay     = 0;
        rsp_addr      = '0;
        req_line      = '0;
        cycle_count   = 0;
        cycle_limit   = 1000;
        cpu_credits   = 0;
        fd = $fopen("dv/cache_trace.txt", "r");
        if (fd == 0) report_failure("cannot open dv/cache_trace.txt");
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() < 2 || text.substr(0, 0) == "#") continue;
            n = $sscanf(text, "%h %h %h %h %h %h",
                        f_op, f_addr, f_size, f_wdata, f_rdata, f_hit);
            if (n == 6) begin
                t_op.push_back(f_op);
                t_addr.push_back(f_addr);
                t_size.push_back(size_t'(f_size));
                t_wdata.push_back(f_wdata);
                t_rdata.push_back(f_rdata);
                t_hit.push_back(f_hit[0]);
            end
        end
        $fclose(fd);
        if (t_op.size() == 0) report_failure("trace file holds no requests");
        cycle_limit = t_op.size() * 64 + 8;
        while (rst_n !== 1'b1) step();
        for (int i = 0; i < t_op.size(); i++) begin
            run_request(i);
        end
        repeat (4) step();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/cache_replace.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
dv/tb_clock.sv
dv/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module cache_tb -f sim.f -o cache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== dv/cache_trace.txt ====
# op (0 read, 1 write, 2 read with memory credits withheld) addr size(0 word 1 byte 2 half)
# wdata expected_rdata expected_hit, all hex; memory word = (addr >> 2) ^ 5a5a0000
2 00000100 0 00000000 5a5a0040 0
0 00000100 0 00000000 5a5a0040 1
0 00000104 0 00000000 5a5a0041 1
0 00000106 1 00000000 0000005a 1
0 00000106 2 00000000 00005a5a 1
1 00000108 0 11223344 00000000 1
1 00000109 1 000000aa 00000000 1
1 0000010a 2 0000beef 00000000 1
0 00000108 0 00000000 beefaa44 1
0 00001040 0 00000000 5a5a0410 0
0 00002040 0 00000000 5a5a0810 0
1 00001044 0 cafef00d 00000000 1
0 00002044 0 00000000 5a5a0811 1
0 00003040 0 00000000 5a5a0c10 0
0 00002040 0 00000000 5a5a0810 1
0 00001044 0 00000000 cafef00d 0
0 00001040 0 00000000 5a5a0410 1
0 00003048 0 00000000 5a5a0c12 0
0 00000500 0 00000000 5a5a0140 0
0 00000900 0 00000000 5a5a0240 0
0 00000108 0 00000000 beefaa44 0
0 0000010a 2 00000000 0000beef 1
0 00000109 1 00000000 000000aa 1
1 00000503 1 00000077 00000000 0
0 00000500 0 00000000 775a0140 1
